// File: logic/rv32i_config.svh
`ifndef RV32I_CONFIG_SVH
`define RV32I_CONFIG_SVH

// Data word width
`define RV_XLEN 32

// Architectural register count and index width
`define RV_NUM_REGS 32
`define RV_REG_IDX_W 5

// PC value held in the pipeline registers after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: logic/rv32i_pkg.sv
`include "rv32i_config.svh"

package rv32i_pkg;

    typedef logic [`RV_XLEN-1:0] rv32i_word;
    typedef logic [`RV_REG_IDX_W-1:0] rv32i_reg;

    // Major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv32i_opcode_t;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops_t;

    // Encoded as the branch funct3 field so branches pass it straight through
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic {
        a1_rs1 = 1'b0,
        a1_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        a2_i_imm = 3'b000,
        a2_u_imm = 3'b001,
        a2_b_imm = 3'b010,
        a2_s_imm = 3'b011,
        a2_j_imm = 3'b100,
        a2_rs2   = 3'b101
    } alumux2_sel_t;

    typedef enum logic {
        cmp_rs2   = 1'b0,
        cmp_i_imm = 1'b1
    } cmpmux_sel_t;

    // Source of the value that is eventually written back
    typedef enum logic [1:0] {
        rf_alu   = 2'b00,
        rf_br_en = 2'b01,
        rf_u_imm = 2'b10
    } regfile_sel_t;

    typedef struct packed {
        rv32i_opcode_t  opcode;
        alu_ops_t       aluop;
        branch_funct3_t cmpop;
        logic           load_regfile;
        logic           mem_read;
        logic           mem_write;
        regfile_sel_t   regfile_sel;
        rv32i_reg       rd;
    } rv32i_control_word;

endpackage

// File: logic/id_ex_if.sv
`timescale 1ns/1ns

interface id_ex_if import rv32i_pkg::*; ();

    rv32i_control_word ctrl;
    rv32i_word         instr;
    rv32i_word         pc;
    rv32i_word         alu_in_1;
    rv32i_word         alu_in_2;
    rv32i_word         cmp_in;
    rv32i_word         rs1_val;
    rv32i_word         rs2_val;

    modport decode (
        output ctrl, instr, pc, alu_in_1, alu_in_2, cmp_in, rs1_val, rs2_val
    );

    modport execute (
        input ctrl, instr, pc, alu_in_1, alu_in_2, cmp_in, rs1_val, rs2_val
    );

endinterface

// File: logic/regfile.sv
`timescale 1ns/1ns
`include "rv32i_config.svh"

module regfile import rv32i_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load,
    input  rv32i_word                in,
    input  logic [`RV_REG_IDX_W-1:0] src_a,
    input  logic [`RV_REG_IDX_W-1:0] src_b,
    input  logic [`RV_REG_IDX_W-1:0] dest,
    output rv32i_word                reg_a,
    output rv32i_word                reg_b
);

    rv32i_word data [`RV_NUM_REGS];

    logic wr_en;

    // x0 is never written, so it can read straight from the array
    assign wr_en = load && (dest != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `RV_NUM_REGS; i++)
            begin
                data[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            data[dest] <= in;
        end
    end

    // Same-cycle bypass lets decode see the value writeback is storing
    assign reg_a = (wr_en && (src_a == dest)) ? in : data[src_a];
    assign reg_b = (wr_en && (src_b == dest)) ? in : data[src_b];

endmodule

// File: logic/control_rom.sv
`timescale 1ns/1ns

module control_rom import rv32i_pkg::*;
(
    input  rv32i_word         data,
    output rv32i_control_word ctrl,
    output alumux1_sel_t      alumux1_sel,
    output alumux2_sel_t      alumux2_sel,
    output cmpmux_sel_t       cmpmux_sel
);

    rv32i_opcode_t opcode;
    logic [2:0]    funct3;
    logic          funct7_5;

    assign opcode   = rv32i_opcode_t'(data[6:0]);
    assign funct3   = data[14:12];
    assign funct7_5 = data[30];

    always_comb
    begin
        ctrl              = '0;
        ctrl.opcode       = opcode;
        ctrl.aluop        = alu_add;
        ctrl.cmpop        = beq;
        ctrl.regfile_sel  = rf_alu;
        alumux1_sel       = a1_rs1;
        alumux2_sel       = a2_i_imm;
        cmpmux_sel        = cmp_rs2;

        unique case (opcode)
            op_lui:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.regfile_sel  = rf_u_imm;
                alumux2_sel       = a2_u_imm;
            end
            op_auipc:
            begin
                ctrl.load_regfile = 1'b1;
                alumux1_sel       = a1_pc;
                alumux2_sel       = a2_u_imm;
            end
            // Only the jump target is formed here, the link value comes from fetch
            op_jal:
            begin
                alumux1_sel = a1_pc;
                alumux2_sel = a2_j_imm;
            end
            op_jalr:
            begin
                alumux2_sel = a2_i_imm;
            end
            op_br:
            begin
                ctrl.cmpop  = branch_funct3_t'(funct3);
                alumux1_sel = a1_pc;
                alumux2_sel = a2_b_imm;
            end
            op_load:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.mem_read     = 1'b1;
            end
            op_store:
            begin
                ctrl.mem_write = 1'b1;
                alumux2_sel    = a2_s_imm;
            end
            op_imm, op_reg:
            begin
                ctrl.load_regfile = 1'b1;
                if (opcode == op_reg)
                begin
                    alumux2_sel = a2_rs2;
                end
                else
                begin
                    cmpmux_sel = cmp_i_imm;
                end
                case (funct3)
                    3'b000: ctrl.aluop = (opcode == op_reg && funct7_5) ? alu_sub : alu_add;
                    3'b001: ctrl.aluop = alu_sll;
                    3'b010:
                    begin
                        ctrl.cmpop       = blt;
                        ctrl.regfile_sel = rf_br_en;
                    end
                    3'b011:
                    begin
                        ctrl.cmpop       = bltu;
                        ctrl.regfile_sel = rf_br_en;
                    end
                    3'b100: ctrl.aluop = alu_xor;
                    3'b101: ctrl.aluop = funct7_5 ? alu_sra : alu_srl;
                    3'b110: ctrl.aluop = alu_or;
                    default: ctrl.aluop = alu_and;
                endcase
            end
            // System instructions and unknown opcodes write nothing
            default:
            begin
                ctrl.load_regfile = 1'b0;
            end
        endcase

        if (ctrl.load_regfile)
        begin
            ctrl.rd = data[11:7];
        end
    end

endmodule

// File: logic/instruction_decode.sv
`timescale 1ns/1ns
`include "rv32i_config.svh"

module instruction_decode import rv32i_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  rv32i_word                pc,
    input  rv32i_word                instr,
    input  rv32i_word                wb_data,
    input  logic [`RV_REG_IDX_W-1:0] wb_rd,
    input  logic                     wb_load,
    id_ex_if.decode                  id_ex
);

    rv32i_word i_imm;
    rv32i_word s_imm;
    rv32i_word b_imm;
    rv32i_word u_imm;
    rv32i_word j_imm;

    rv32i_control_word ctrl;
    alumux1_sel_t      alumux1_sel;
    alumux2_sel_t      alumux2_sel;
    cmpmux_sel_t       cmpmux_sel;

    rv32i_word reg_a;
    rv32i_word reg_b;
    rv32i_word alu_in_1;
    rv32i_word alu_in_2;
    rv32i_word cmp_in;

    // ******************************************************************
    // Immediate formats
    // ******************************************************************

    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    regfile i_regfile (
        .clk   (clk),
        .rst   (rst),
        .load  (wb_load),
        .in    (wb_data),
        .src_a (instr[19:15]),
        .src_b (instr[24:20]),
        .dest  (wb_rd),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    control_rom i_control_rom (
        .data        (instr),
        .ctrl        (ctrl),
        .alumux1_sel (alumux1_sel),
        .alumux2_sel (alumux2_sel),
        .cmpmux_sel  (cmpmux_sel)
    );

    // ******************************************************************
    // Operand selection
    // ******************************************************************

    always_comb
    begin
        alu_in_1 = (alumux1_sel == a1_pc) ? pc : reg_a;

        unique case (alumux2_sel)
            a2_i_imm: alu_in_2 = i_imm;
            a2_u_imm: alu_in_2 = u_imm;
            a2_b_imm: alu_in_2 = b_imm;
            a2_s_imm: alu_in_2 = s_imm;
            a2_j_imm: alu_in_2 = j_imm;
            default:  alu_in_2 = reg_b;
        endcase

        cmp_in = (cmpmux_sel == cmp_i_imm) ? i_imm : reg_b;
    end

    // ID/EX boundary
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            id_ex.ctrl     <= '0;
            id_ex.instr    <= '0;
            id_ex.pc       <= `RV_RESET_PC;
            id_ex.alu_in_1 <= '0;
            id_ex.alu_in_2 <= '0;
            id_ex.cmp_in   <= '0;
            id_ex.rs1_val  <= '0;
            id_ex.rs2_val  <= '0;
        end
        else if (!stall)
        begin
            id_ex.ctrl     <= ctrl;
            id_ex.instr    <= instr;
            id_ex.pc       <= pc;
            id_ex.alu_in_1 <= alu_in_1;
            id_ex.alu_in_2 <= alu_in_2;
            id_ex.cmp_in   <= cmp_in;
            id_ex.rs1_val  <= reg_a;
            id_ex.rs2_val  <= reg_b;
        end
    end

endmodule

// File: logic/execute.sv
`timescale 1ns/1ns
`include "rv32i_config.svh"

module execute import rv32i_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    id_ex_if.execute                 id_ex,
    output rv32i_word                alu_out,
    output rv32i_word                rs2_out,
    output rv32i_word                pc_out,
    output logic                     br_en,
    output logic                     load_regfile,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic [`RV_REG_IDX_W-1:0] rd
);

    rv32i_word  alu_result;
    rv32i_word  wb_value;
    rv32i_word  store_data;
    logic [4:0] shamt;
    logic       cmp_out;
    logic       take;

    assign shamt = id_ex.alu_in_2[4:0];

    always_comb
    begin
        unique case (id_ex.ctrl.aluop)
            alu_add: alu_result = id_ex.alu_in_1 + id_ex.alu_in_2;
            alu_sll: alu_result = id_ex.alu_in_1 << shamt;
            alu_sra: alu_result = rv32i_word'($signed(id_ex.alu_in_1) >>> shamt);
            alu_sub: alu_result = id_ex.alu_in_1 - id_ex.alu_in_2;
            alu_xor: alu_result = id_ex.alu_in_1 ^ id_ex.alu_in_2;
            alu_srl: alu_result = id_ex.alu_in_1 >> shamt;
            alu_or:  alu_result = id_ex.alu_in_1 | id_ex.alu_in_2;
            default: alu_result = id_ex.alu_in_1 & id_ex.alu_in_2;
        endcase

        case (id_ex.ctrl.cmpop)
            beq:     cmp_out = (id_ex.rs1_val == id_ex.cmp_in);
            bne:     cmp_out = (id_ex.rs1_val != id_ex.cmp_in);
            blt:     cmp_out = ($signed(id_ex.rs1_val) < $signed(id_ex.cmp_in));
            bge:     cmp_out = ($signed(id_ex.rs1_val) >= $signed(id_ex.cmp_in));
            bltu:    cmp_out = (id_ex.rs1_val < id_ex.cmp_in);
            bgeu:    cmp_out = (id_ex.rs1_val >= id_ex.cmp_in);
            default: cmp_out = 1'b0;
        endcase

        unique case (id_ex.ctrl.regfile_sel)
            rf_br_en: wb_value = {{(`RV_XLEN-1){1'b0}}, cmp_out};
            rf_u_imm: wb_value = id_ex.alu_in_2;
            default:  wb_value = alu_result;
        endcase

        // Jumps always redirect, conditional branches follow the comparator
        unique case (id_ex.ctrl.opcode)
            op_br:          take = cmp_out;
            op_jal, op_jalr: take = 1'b1;
            default:        take = 1'b0;
        endcase

        // Narrow stores replicate the low bytes across the data bus
        if (id_ex.ctrl.mem_write && id_ex.instr[14:12] == 3'b000)
            store_data = {4{id_ex.rs2_val[7:0]}};
        else if (id_ex.ctrl.mem_write && id_ex.instr[14:12] == 3'b001)
            store_data = {2{id_ex.rs2_val[15:0]}};
        else
            store_data = id_ex.rs2_val;
    end

    // EX/MEM boundary
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            alu_out      <= '0;
            rs2_out      <= '0;
            pc_out       <= `RV_RESET_PC;
            br_en        <= 1'b0;
            load_regfile <= 1'b0;
            mem_read     <= 1'b0;
            mem_write    <= 1'b0;
            rd           <= '0;
        end
        else if (!stall)
        begin
            alu_out      <= wb_value;
            rs2_out      <= store_data;
            pc_out       <= id_ex.pc;
            br_en        <= take;
            load_regfile <= id_ex.ctrl.load_regfile;
            mem_read     <= id_ex.ctrl.mem_read;
            mem_write    <= id_ex.ctrl.mem_write;
            rd           <= id_ex.ctrl.rd;
        end
    end

endmodule

// File: logic/rv32i_id_ex_top.sv
`timescale 1ns/1ns
`include "rv32i_config.svh"

module rv32i_id_ex_top
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`RV_XLEN-1:0]      pc,
    input  logic [`RV_XLEN-1:0]      instr,
    input  logic                     stall,
    input  logic [`RV_XLEN-1:0]      wb_data,
    input  logic [`RV_REG_IDX_W-1:0] wb_rd,
    input  logic                     wb_load,
    output logic [`RV_XLEN-1:0]      ex_alu_out,
    output logic                     ex_br_en,
    output logic [`RV_XLEN-1:0]      ex_rs2,
    output logic [`RV_REG_IDX_W-1:0] ex_rd,
    output logic                     ex_load_regfile,
    output logic                     ex_mem_read,
    output logic                     ex_mem_write,
    output logic [`RV_XLEN-1:0]      ex_pc
);

    id_ex_if id_ex ();

    instruction_decode i_instruction_decode (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .pc      (pc),
        .instr   (instr),
        .wb_data (wb_data),
        .wb_rd   (wb_rd),
        .wb_load (wb_load),
        .id_ex   (id_ex.decode)
    );

    execute i_execute (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .id_ex        (id_ex.execute),
        .alu_out      (ex_alu_out),
        .rs2_out      (ex_rs2),
        .pc_out       (ex_pc),
        .br_en        (ex_br_en),
        .load_regfile (ex_load_regfile),
        .mem_read     (ex_mem_read),
        .mem_write    (ex_mem_write),
        .rd           (ex_rd)
    );

endmodule

// File: verification/rv32i_id_ex_sva.sv
`timescale 1ns/1ns
`include "rv32i_config.svh"

module rv32i_id_ex_sva
(
    input logic                     clk,
    input logic                     rst,
    input logic                     stall,
    input logic [`RV_XLEN-1:0]      instr,
    input logic [`RV_XLEN-1:0]      wb_data,
    input logic [`RV_REG_IDX_W-1:0] wb_rd,
    input logic                     wb_load,
    input logic [`RV_XLEN-1:0]      ex_alu_out,
    input logic                     ex_br_en,
    input logic [`RV_XLEN-1:0]      ex_rs2,
    input logic [`RV_REG_IDX_W-1:0] ex_rd,
    input logic                     ex_load_regfile,
    input logic                     ex_mem_read,
    input logic                     ex_mem_write,
    input logic [`RV_XLEN-1:0]      ex_pc,
    input logic [`RV_XLEN-1:0]      rf_reg_a,
    input logic [`RV_XLEN-1:0]      rf_reg_b
);

    int fail_count = 0;

    logic reset_state;

    assign reset_state = !ex_load_regfile && !ex_mem_read && !ex_mem_write
                         && (ex_pc == `RV_RESET_PC);

    // **********************************************************************
    // Reset and stall behavior of the EX/MEM outputs
    // **********************************************************************

    a_reset_hold: assert property (@(posedge clk) rst |=> reset_state)
    else
    begin
        fail_count++;
        $error("EX outputs not in reset state while rst is high");
    end

    a_reset_release: assert property (@(posedge clk) $fell(rst) |=> reset_state)
    else
    begin
        fail_count++;
        $error("EX outputs left reset state on the first cycle after reset");
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall |=> ($stable(ex_alu_out) && $stable(ex_br_en) && $stable(ex_rs2)
                   && $stable(ex_rd) && $stable(ex_load_regfile) && $stable(ex_mem_read)
                   && $stable(ex_mem_write) && $stable(ex_pc)))
    else
    begin
        fail_count++;
        $error("EX outputs changed across a stalled clock edge");
    end

    // **********************************************************************
    // Register zero and writeback bypass on the decode read ports
    // **********************************************************************

    a_x0_read_a: assert property (@(posedge clk) disable iff (rst)
        (instr[19:15] == '0) |-> (rf_reg_a == '0))
    else
    begin
        fail_count++;
        $error("Read of x0 on port a returned a nonzero value");
    end

    a_x0_read_b: assert property (@(posedge clk) disable iff (rst)
        (instr[24:20] == '0) |-> (rf_reg_b == '0))
    else
    begin
        fail_count++;
        $error("Read of x0 on port b returned a nonzero value");
    end

    a_bypass_a: assert property (@(posedge clk) disable iff (rst)
        (wb_load && (wb_rd != '0) && (instr[19:15] == wb_rd)) |-> (rf_reg_a == wb_data))
    else
    begin
        fail_count++;
        $error("Port a missed the same-cycle writeback value");
    end

    a_bypass_b: assert property (@(posedge clk) disable iff (rst)
        (wb_load && (wb_rd != '0) && (instr[24:20] == wb_rd)) |-> (rf_reg_b == wb_data))
    else
    begin
        fail_count++;
        $error("Port b missed the same-cycle writeback value");
    end

endmodule

bind rv32i_id_ex_top rv32i_id_ex_sva i_rv32i_id_ex_sva (
    .clk             (clk),
    .rst             (rst),
    .stall           (stall),
    .instr           (instr),
    .wb_data         (wb_data),
    .wb_rd           (wb_rd),
    .wb_load         (wb_load),
    .ex_alu_out      (ex_alu_out),
    .ex_br_en        (ex_br_en),
    .ex_rs2          (ex_rs2),
    .ex_rd           (ex_rd),
    .ex_load_regfile (ex_load_regfile),
    .ex_mem_read     (ex_mem_read),
    .ex_mem_write    (ex_mem_write),
    .ex_pc           (ex_pc),
    .rf_reg_a        (i_instruction_decode.reg_a),
    .rf_reg_b        (i_instruction_decode.reg_b)
);

// File: verification/rv32i_id_ex_tb.sv
`timescale 1ns/1ns
`include "rv32i_config.svh"

module rv32i_id_ex_tb;

    localparam int NUM_INSTR  = 3000;
    localparam int CLK_PERIOD = 8;
    localparam int TIMEOUT_NS = NUM_INSTR * CLK_PERIOD * 2 + 2000;

    // addi x0, x0, 0
    localparam logic [31:0] NOP = 32'h0000_0013;

    typedef enum int {
        k_add, k_sub, k_xor, k_or, k_and, k_sll, k_srl, k_sra, k_slt, k_sltu,
        k_addi, k_lui, k_auipc,
        k_beq, k_bne, k_blt, k_bge, k_bltu, k_bgeu,
        k_sw, k_lw
    } kind_t;

    typedef struct packed {
        logic [31:0] alu_out;
        logic        br_en;
        logic        chk_rs2;
        logic [31:0] rs2;
        logic [4:0]  rd;
        logic        load_regfile;
        logic        mem_read;
        logic        mem_write;
        logic [31:0] pc;
    } expect_t;

    logic                     clk;
    logic                     rst;
    logic [`RV_XLEN-1:0]      pc;
    logic [`RV_XLEN-1:0]      instr;
    logic                     stall;
    logic [`RV_XLEN-1:0]      wb_data;
    logic [`RV_REG_IDX_W-1:0] wb_rd;
    logic                     wb_load;
    logic [`RV_XLEN-1:0]      ex_alu_out;
    logic                     ex_br_en;
    logic [`RV_XLEN-1:0]      ex_rs2;
    logic [`RV_REG_IDX_W-1:0] ex_rd;
    logic                     ex_load_regfile;
    logic                     ex_mem_read;
    logic                     ex_mem_write;
    logic [`RV_XLEN-1:0]      ex_pc;

    logic [31:0] shadow [`RV_NUM_REGS];
    expect_t     exp_q [$];
    expect_t     cur;
    logic        cur_active;
    logic        cur_stall;
    logic        captured;
    logic [31:0] next_pc;
    int          stall_left;
    int          checks;
    int          errors;

    rv32i_id_ex_top i_rv32i_id_ex_top (
        .clk             (clk),
        .rst             (rst),
        .pc              (pc),
        .instr           (instr),
        .stall           (stall),
        .wb_data         (wb_data),
        .wb_rd           (wb_rd),
        .wb_load         (wb_load),
        .ex_alu_out      (ex_alu_out),
        .ex_br_en        (ex_br_en),
        .ex_rs2          (ex_rs2),
        .ex_rd           (ex_rd),
        .ex_load_regfile (ex_load_regfile),
        .ex_mem_read     (ex_mem_read),
        .ex_mem_write    (ex_mem_write),
        .ex_pc           (ex_pc)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not complete within %0d ns", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    // **********************************************************************
    // Reference rules for RV32I results
    // **********************************************************************

    function automatic logic [2:0] r_funct3(input kind_t kind);
        case (kind)
            k_sll:          return 3'b001;
            k_slt:          return 3'b010;
            k_sltu:         return 3'b011;
            k_xor:          return 3'b100;
            k_srl, k_sra:   return 3'b101;
            k_or:           return 3'b110;
            k_and:          return 3'b111;
            default:        return 3'b000;
        endcase
    endfunction

    function automatic logic [31:0] r_result(input kind_t kind, input logic [31:0] a,
                                             input logic [31:0] b);
        case (kind)
            k_sub:   return a - b;
            k_xor:   return a ^ b;
            k_or:    return a | b;
            k_and:   return a & b;
            k_sll:   return a << b[4:0];
            k_srl:   return a >> b[4:0];
            k_sra:   return $unsigned($signed(a) >>> b[4:0]);
            k_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            k_sltu:  return (a < b) ? 32'd1 : 32'd0;
            default: return a + b;
        endcase
    endfunction

    function automatic logic [2:0] b_funct3(input kind_t kind);
        case (kind)
            k_bne:   return 3'b001;
            k_blt:   return 3'b100;
            k_bge:   return 3'b101;
            k_bltu:  return 3'b110;
            k_bgeu:  return 3'b111;
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic b_taken(input kind_t kind, input logic [31:0] a,
                                     input logic [31:0] b);
        case (kind)
            k_bne:   return a != b;
            k_blt:   return $signed(a) < $signed(b);
            k_bge:   return $signed(a) >= $signed(b);
            k_bltu:  return a < b;
            k_bgeu:  return a >= b;
            default: return a == b;
        endcase
    endfunction

    task automatic build_instr(
        input  kind_t       kind,
        input  logic [4:0]  rd,
        input  logic [4:0]  rs1,
        input  logic [4:0]  rs2,
        input  logic [31:0] imm,
        input  logic [31:0] a,
        input  logic [31:0] b,
        input  logic [31:0] pc_val,
        output logic [31:0] word,
        output expect_t     e
    );
        logic [31:0] i_imm;
        logic [31:0] b_imm;
        logic [31:0] u_imm;
        logic [6:0]  funct7;

        i_imm  = {{20{imm[11]}}, imm[11:0]};
        b_imm  = {{19{imm[12]}}, imm[12:1], 1'b0};
        u_imm  = {imm[31:12], 12'h000};
        funct7 = (kind == k_sub || kind == k_sra) ? 7'b0100000 : 7'b0000000;
        e      = '0;
        e.pc   = pc_val;

        if (kind <= k_sltu)
        begin
            word           = {funct7, rs2, rs1, r_funct3(kind), rd, 7'b0110011};
            e.alu_out      = r_result(kind, a, b);
            e.rd           = rd;
            e.load_regfile = 1'b1;
        end
        else if (kind >= k_beq && kind <= k_bgeu)
        begin
            word      = {imm[12], imm[10:5], rs2, rs1, b_funct3(kind),
                         imm[4:1], imm[11], 7'b1100011};
            e.alu_out = pc_val + b_imm;
            e.br_en   = b_taken(kind, a, b);
        end
        else if (kind == k_sw)
        begin
            word        = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            e.alu_out   = a + i_imm;
            e.mem_write = 1'b1;
            e.rs2       = b;
            e.chk_rs2   = 1'b1;
        end
        else
        begin
            e.rd           = rd;
            e.load_regfile = 1'b1;
            case (kind)
                k_addi:
                begin
                    word      = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
                    e.alu_out = a + i_imm;
                end
                k_lui:
                begin
                    word      = {imm[31:12], rd, 7'b0110111};
                    e.alu_out = u_imm;
                end
                k_auipc:
                begin
                    word      = {imm[31:12], rd, 7'b0010111};
                    e.alu_out = pc_val + u_imm;
                end
                default:
                begin
                    word       = {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
                    e.alu_out  = a + i_imm;
                    e.mem_read = 1'b1;
                end
            endcase
        end
    endtask

    // **********************************************************************
    // Stimulus and checking
    // **********************************************************************

    task automatic drive_writeback(input logic [4:0] idx, input logic [31:0] val);
        wb_load <= 1'b1;
        wb_rd   <= idx;
        wb_data <= val;
        if (idx != 5'd0)
        begin
            shadow[idx] = val;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compare_entry(input expect_t e);
        check_word("ex_alu_out", ex_alu_out, e.alu_out);
        check_word("ex_br_en", {31'b0, ex_br_en}, {31'b0, e.br_en});
        check_word("ex_rd", {27'b0, ex_rd}, {27'b0, e.rd});
        check_word("ex_load_regfile", {31'b0, ex_load_regfile}, {31'b0, e.load_regfile});
        check_word("ex_mem_read", {31'b0, ex_mem_read}, {31'b0, e.mem_read});
        check_word("ex_mem_write", {31'b0, ex_mem_write}, {31'b0, e.mem_write});
        check_word("ex_pc", ex_pc, e.pc);
        if (e.chk_rs2)
        begin
            check_word("ex_rs2", ex_rs2, e.rs2);
        end
    endtask

    task automatic issue_cycle(input logic allow_stall);
        logic [31:0] rnd;
        logic [31:0] imm;
        logic [31:0] word;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  wr_idx;
        logic        wr_en;
        kind_t       kind;
        expect_t     e;

        // Writeback keeps going through stalls
        rnd    = $urandom();
        wr_en  = rnd[0];
        wr_idx = rnd[12:8];
        if (wr_en)
        begin
            drive_writeback(wr_idx, $urandom());
        end
        else
        begin
            wb_load <= 1'b0;
        end

        rnd = $urandom();
        if (!allow_stall)
        begin
            stall_left = 0;
        end
        else if (stall_left == 0 && rnd[3:0] == 4'h0)
        begin
            stall_left = int'(rnd[5:4]) + 1;
        end
        cur_stall = (stall_left > 0);
        stall    <= cur_stall;

        if (cur_stall)
        begin
            stall_left--;
            cur_active = 1'b0;
        end
        else
        begin
            rnd = $urandom();
            rs1 = rnd[4:0];
            rs2 = rnd[9:5];
            rd  = rnd[14:10];
            // Point sources at the register being written to reach the bypass
            if (wr_en && rnd[16:15] == 2'b00)
            begin
                rs1 = wr_idx;
            end
            if (wr_en && rnd[18:17] == 2'b00)
            begin
                rs2 = wr_idx;
            end
            kind = kind_t'(int'(rnd[31:24]) % 21);
            imm  = $urandom();
            build_instr(kind, rd, rs1, rs2, imm, shadow[rs1], shadow[rs2], next_pc, word, e);
            instr     <= word;
            pc        <= next_pc;
            cur        = e;
            cur_active = 1'b1;
            next_pc    = next_pc + 32'd4;
        end
    endtask

    initial
    begin
        int unsigned seed_init;

        seed_init = $urandom(32'h0173_515f);
        rst     <= 1'b1;
        stall   <= 1'b0;
        pc      <= `RV_RESET_PC;
        instr   <= NOP;
        wb_data <= '0;
        wb_rd   <= '0;
        wb_load <= 1'b0;
        for (int r = 0; r < `RV_NUM_REGS; r++)
        begin
            shadow[r] = '0;
        end
        cur        = '0;
        cur_active = 1'b0;
        cur_stall  = 1'b0;
        captured   = 1'b0;
        next_pc    = 32'h0000_1000 ^ (seed_init & 32'h0000_0ffc);
        stall_left = 0;
        checks     = 0;
        errors     = 0;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < `RV_NUM_REGS; r++)
        begin
            @(posedge clk);
            drive_writeback(r[4:0], $urandom());
        end

        // The last two cycles never stall, so the final instructions drain out
        for (int n = 0; n < NUM_INSTR + 2; n++)
        begin
            @(posedge clk);
            captured = cur_active && !cur_stall;
            if (captured)
            begin
                exp_q.push_back(cur);
            end
            issue_cycle(n < NUM_INSTR);
            @(negedge clk);
            if (captured && exp_q.size() > 1)
            begin
                compare_entry(exp_q.pop_front());
            end
        end

        $display("Checks: %0d, scoreboard errors: %0d, assertion failures: %0d",
                 checks, errors, i_rv32i_id_ex_top.i_rv32i_id_ex_sva.fail_count);
        if (errors == 0 && i_rv32i_id_ex_top.i_rv32i_id_ex_sva.fail_count == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+logic
logic/rv32i_pkg.sv
logic/id_ex_if.sv
logic/regfile.sv
logic/control_rom.sv
logic/instruction_decode.sv
logic/execute.sv
logic/rv32i_id_ex_top.sv
verification/rv32i_id_ex_sva.sv
verification/rv32i_id_ex_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the decode/execute slice with Verilator, run it, and judge the log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f flist.f --top-module rv32i_id_ex_tb \
    -o rv32i_id_ex_sim > sim.log 2>&1 &&
    ./obj_dir/rv32i_id_ex_sim +verilator+error+limit+1000 >> sim.log 2>&1

grep -qx "NO ERRORS" sim.log && echo "Simulation passed, see sim.log" ||
    { echo "Simulation failed, see sim.log"; exit 1; }
